// ==== sim.f ====
src/box_pkg.sv
src/delay_line.sv
src/line_buffer.sv
src/adder_stage.sv
src/frame_ctrl.sv
src/window_sum.sv
src/binarize.sv
src/local_mean_top.sv
test/tb_local_mean.sv

// ==== Makefile ====
TOP := tb_local_mean

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// ==== test/tb_local_mean.sv ====
`timescale 1ns/100ps

module tb_local_mean;

  import box_pkg::*;

  localparam int N_OUT     = (IMG_ROWS - WIN + 1) * (IMG_COLS - WIN + 1);
  localparam int MAX_GAP   = 7;
  localparam int FRAME_CYC = IMG_ROWS * (IMG_COLS + MAX_GAP) + 2 * PIPE_LAT;
  // eight frames worth of streaming, counting the partial one
  localparam int LIMIT     = 2 * 8 * FRAME_CYC + 200;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     sof;
  logic     pix_valid;
  pix_t     pix;
  logic     bin_valid;
  logic     bin;
  win_sum_t win_sum;
  pix_t     centre;

  pix_t frame [IMG_ROWS][IMG_COLS];
  int   exp_sum [$];
  int   exp_centre [$];
  bit   exp_bin [$];
  int   corner_q [$];
  int   cyc = 0;
  int   errors = 0;
  int   out_cnt = 0;
  int   ones_cnt = 0;
  int   e_sum;
  int   e_centre;
  bit   e_bin;
  int   corner;

  local_mean_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_sof       (sof),
    .i_pix_valid (pix_valid),
    .i_pix       (pix),
    .o_bin_valid (bin_valid),
    .o_bin       (bin),
    .o_win_sum   (win_sum),
    .o_centre    (centre)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cyc);
      $display("TB FAILED");
      $finish;
    end
  end

  // ------------------------------
  // output monitor
  // ------------------------------
  always @(negedge clk) begin
    if (bin_valid === 1'b1) begin
      if (exp_sum.size() == 0) begin
        $display("Error at %0t: o_bin_valid with no output expected", $time);
        errors++;
      end else begin
        e_sum    = exp_sum.pop_front();
        e_centre = exp_centre.pop_front();
        e_bin    = exp_bin.pop_front();
        // first output of a frame, latency from the corner pixel
        if (out_cnt % N_OUT == 0) begin
          if (corner_q.size() == 0) begin
            $display("Error at %0t: frame output came before its corner pixel", $time);
            errors++;
          end else begin
            corner = corner_q.pop_front();
            if (cyc - corner != PIPE_LAT) begin
              $display("Mismatch at %0t: latency %0d, expected %0d", $time, cyc - corner,
                       PIPE_LAT);
              errors++;
            end
          end
        end
        if (win_sum !== SUM_W'(e_sum)) begin
          $display("Mismatch at %0t: sum %0d, expected %0d", $time, win_sum, e_sum);
          errors++;
        end
        if (centre !== PIX_W'(e_centre)) begin
          $display("Mismatch at %0t: centre %0d, expected %0d", $time, centre, e_centre);
          errors++;
        end
        if (bin !== e_bin) begin
          $display("Mismatch at %0t: bit %0b, expected %0b", $time, bin, e_bin);
          errors++;
        end
        if (bin === 1'b1) begin
          ones_cnt++;
        end
        out_cnt++;
      end
    end
  end

  // window sum, centre and bit for every interior window, raster order
  task automatic model_frame();
    int s;
    int ctr;
    for (int r = WIN - 1; r < IMG_ROWS; r++) begin
      for (int c = WIN - 1; c < IMG_COLS; c++) begin
        s = 0;
        for (int i = 0; i < WIN; i++) begin
          for (int j = 0; j < WIN; j++) begin
            s += frame[r-WIN+1+i][c-WIN+1+j];
          end
        end
        ctr = frame[r-WIN/2][c-WIN/2];
        exp_sum.push_back(s);
        exp_centre.push_back(ctr);
        exp_bin.push_back(ctr * WIN_AREA > s);
      end
    end
  endtask

  task automatic fill_const(input int v);
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        frame[r][c] = PIX_W'(v);
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        frame[r][c] = PIX_W'($urandom);
      end
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic stream_rows(input int n_rows, input bit vary, input int tail_gap);
    int gap;
    for (int r = 0; r < n_rows; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        @(posedge clk);
        #1;
        sof       = (r == 0 && c == 0);
        pix_valid = 1'b1;
        pix       = frame[r][c];
        if (r == WIN - 1 && c == WIN - 1) begin
          corner_q.push_back(cyc);
        end
      end
      gap = (r == n_rows - 1) ? tail_gap : (vary ? (r % 4) * 2 : 2);
      repeat (gap) begin
        @(posedge clk);
        #1;
        sof       = 1'b0;
        pix_valid = 1'b0;
      end
    end
  endtask

  task automatic drain();
    @(posedge clk);
    #1;
    sof       = 1'b0;
    pix_valid = 1'b0;
    while (exp_sum.size() != 0) begin
      @(posedge clk);
    end
    // room for any stray strobe
    repeat (PIPE_LAT + 2) @(posedge clk);
  endtask

  task automatic check_count(input int start, input int n_frames, input string name);
    if (out_cnt - start != n_frames * N_OUT) begin
      $display("Mismatch at %0t: %s gave %0d outputs, expected %0d", $time, name,
               out_cnt - start, n_frames * N_OUT);
      errors++;
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_uniform();
    int start;
    start = out_cnt;
    fill_const(10);
    model_frame();
    stream_rows(IMG_ROWS, 1'b0, 0);
    drain();
    check_count(start, 1, "uniform frame");
  endtask

  task automatic test_bright_pixel();
    int start;
    int ones_start;
    start      = out_cnt;
    ones_start = ones_cnt;
    fill_const(20);
    frame[6][11] = 8'd200;
    model_frame();
    stream_rows(IMG_ROWS, 1'b0, 0);
    drain();
    check_count(start, 1, "bright pixel frame");
    if (ones_cnt - ones_start != 1) begin
      $display("Mismatch at %0t: %0d foreground bits, expected 1", $time,
               ones_cnt - ones_start);
      errors++;
    end
  endtask

  task automatic test_random();
    int start;
    start = out_cnt;
    for (int f = 0; f < 2; f++) begin
      fill_random();
      model_frame();
      stream_rows(IMG_ROWS, 1'b0, 0);
      drain();
    end
    check_count(start, 2, "random frames");
  endtask

  task automatic test_gaps_back_to_back();
    int start;
    start = out_cnt;
    // aborted frame, the next sof must restart the counters
    fill_random();
    stream_rows(5, 1'b1, 3);
    fill_random();
    model_frame();
    stream_rows(IMG_ROWS, 1'b1, 0);
    fill_random();
    model_frame();
    stream_rows(IMG_ROWS, 1'b1, 0);
    drain();
    check_count(start, 2, "gapped frames");
  endtask

  task automatic test_saturated();
    int start;
    start = out_cnt;
    fill_const(255);
    model_frame();
    stream_rows(IMG_ROWS, 1'b0, 0);
    drain();
    check_count(start, 1, "all-255 frame");
  endtask

  initial begin
    rst_n     = 1'b0;
    sof       = 1'b0;
    pix_valid = 1'b0;
    pix       = '0;
    void'($urandom(25));
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);

    test_uniform();
    test_bright_pixel();
    test_random();
    test_gaps_back_to_back();
    test_saturated();

    if (exp_sum.size() != 0) begin
      $display("Error: %0d expected outputs never arrived", exp_sum.size());
      errors++;
    end
    $display("errors: %0d, outputs checked: %0d", errors, out_cnt);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== src/local_mean_top.sv ====
`timescale 1ns/100ps

module local_mean_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_sof,
  input  logic              i_pix_valid,
  input  box_pkg::pix_t     i_pix,
  output logic              o_bin_valid,
  output logic              o_bin,
  output box_pkg::win_sum_t o_win_sum,
  output box_pkg::pix_t     o_centre
);

  import box_pkg::*;

  logic                 accept;
  logic [COL_IDX_W-1:0] col;
  logic                 ld;
  logic                 sub_en;
  logic                 win_done;
  pix_t                 col_pix [WIN];
  logic                 col_valid;
  win_sum_t             sum;
  pix_t                 centre;
  logic                 sum_valid;

  frame_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_sof       (i_sof),
    .i_pix_valid (i_pix_valid),
    .o_accept    (accept),
    .o_col       (col),
    .o_ld        (ld),
    .o_sub_en    (sub_en),
    .o_win_done  (win_done)
  );

  line_buffer u_lbuf (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_accept    (accept),
    .i_col       (col),
    .i_pix       (i_pix),
    .o_col_pix   (col_pix),
    .o_col_valid (col_valid)
  );

  window_sum u_wsum (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_col_pix   (col_pix),
    .i_col_valid (col_valid),
    .i_ld        (ld),
    .i_sub_en    (sub_en),
    .i_win_done  (win_done),
    .o_sum       (sum),
    .o_centre    (centre),
    .o_sum_valid (sum_valid)
  );

  binarize u_bin (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_sum       (sum),
    .i_centre    (centre),
    .i_valid     (sum_valid),
    .o_bin_valid (o_bin_valid),
    .o_bin       (o_bin),
    .o_win_sum   (o_win_sum),
    .o_centre    (o_centre)
  );

endmodule

// ==== src/binarize.sv ====
`timescale 1ns/100ps

module binarize (
  input  logic              clk,
  input  logic              rst_n,
  input  box_pkg::win_sum_t i_sum,
  input  box_pkg::pix_t     i_centre,
  input  logic              i_valid,
  output logic              o_bin_valid,
  output logic              o_bin,
  output box_pkg::win_sum_t o_win_sum,
  output box_pkg::pix_t     o_centre
);

  import box_pkg::*;

  win_sum_t centre_scaled;

  // centre > mean without a divide
  assign centre_scaled = win_sum_t'(i_centre) * win_sum_t'(WIN_AREA);

  always_ff @(posedge clk) begin
    o_bin     <= (centre_scaled > i_sum);
    o_win_sum <= i_sum;
    o_centre  <= i_centre;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_bin_valid <= 1'b0;
    end else begin
      o_bin_valid <= i_valid;
    end
  end

endmodule

// ==== src/window_sum.sv ====
`timescale 1ns/100ps

module window_sum (
  input  logic              clk,
  input  logic              rst_n,
  input  box_pkg::pix_t     i_col_pix [box_pkg::WIN],
  input  logic              i_col_valid,
  input  logic              i_ld,
  input  logic              i_sub_en,
  input  logic              i_win_done,
  output box_pkg::win_sum_t o_sum,
  output box_pkg::pix_t     o_centre,
  output logic              o_sum_valid
);

  import box_pkg::*;

  pix_t             col_q [WIN];
  logic [PIX_W:0]   pair_sum [4];
  logic [PIX_W+1:0] quad_sum [2];
  logic [COL_W-2:0] oct_sum;
  pix_t             ninth_q;
  logic [COL_W-2:0] ninth_ext;
  col_sum_t         col_sum;
  col_sum_t         col_old;
  logic             ld_q;
  logic             sub_q;
  logic             win_q;
  logic             cv_q;
  logic [SUM_W:0]   old_ext;
  logic [SUM_W:0]   acc_ext;
  win_sum_t         run_sum;

  // input register
  always_ff @(posedge clk) begin
    col_q <= i_col_pix;
  end

  // ------------------------------
  // column adder tree
  // ------------------------------
  for (genvar p = 0; p < 4; p++) begin : g_pair
    adder_stage #(.WIDTH(PIX_W)) u_pair (
      .clk   (clk),
      .rst_n (rst_n),
      .i_a   (col_q[2*p]),
      .i_b   (col_q[2*p+1]),
      .o_sum (pair_sum[p])
    );
  end

  for (genvar q = 0; q < 2; q++) begin : g_quad
    adder_stage #(.WIDTH(PIX_W + 1)) u_quad (
      .clk   (clk),
      .rst_n (rst_n),
      .i_a   (pair_sum[2*q]),
      .i_b   (pair_sum[2*q+1]),
      .o_sum (quad_sum[q])
    );
  end

  adder_stage #(.WIDTH(PIX_W + 2)) u_oct (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (quad_sum[0]),
    .i_b   (quad_sum[1]),
    .o_sum (oct_sum)
  );

  // bottom pixel waits out the three tree levels
  delay_line #(.T(pix_t), .DEPTH(3)) u_ninth_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (col_q[WIN-1]),
    .o_q   (ninth_q)
  );

  assign ninth_ext = (COL_W - 1)'(ninth_q);

  adder_stage #(.WIDTH(COL_W - 1)) u_col_add (
    .clk   (clk),
    .rst_n (rst_n),
    .i_a   (oct_sum),
    .i_b   (ninth_ext),
    .o_sum (col_sum)
  );

  // ------------------------------
  // history and strobe alignment
  // ------------------------------
  delay_line #(.T(col_sum_t), .DEPTH(WIN)) u_hist (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (col_sum),
    .o_q   (col_old)
  );

  // four columns back plus five stages after col_q
  delay_line #(.T(pix_t), .DEPTH(WIN)) u_centre (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (col_q[WIN/2]),
    .o_q   (o_centre)
  );

  // strobes line up with col_sum
  delay_line #(.T(logic), .DEPTH(PIPE_LAT - 2)) u_ld_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_ld),
    .o_q   (ld_q)
  );

  delay_line #(.T(logic), .DEPTH(PIPE_LAT - 2)) u_sub_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_sub_en),
    .o_q   (sub_q)
  );

  delay_line #(.T(logic), .DEPTH(PIPE_LAT - 2)) u_win_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_win_done),
    .o_q   (win_q)
  );

  // column valid is already one cycle in
  delay_line #(.T(logic), .DEPTH(PIPE_LAT - 3)) u_cv_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (i_col_valid),
    .o_q   (cv_q)
  );

  // running horizontal sum
  assign old_ext = sub_q ? (SUM_W + 1)'(col_old) : '0;
  assign acc_ext = {1'b0, run_sum} + (SUM_W + 1)'(col_sum) - old_ext;

  always_ff @(posedge clk) begin
    if (cv_q) begin
      if (ld_q) begin
        run_sum <= win_sum_t'(col_sum);
      end else begin
        run_sum <= acc_ext[SUM_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_sum_valid <= 1'b0;
    end else begin
      o_sum_valid <= cv_q && win_q;
    end
  end

  assign o_sum = run_sum;

  // history must hold exactly the column added nine columns ago
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    (cv_q && win_q && sub_q && !ld_q) |-> !acc_ext[SUM_W]);

endmodule

// ==== src/frame_ctrl.sv ====
`timescale 1ns/100ps

module frame_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_sof,
  input  logic                          i_pix_valid,
  output logic                          o_accept,
  output logic [box_pkg::COL_IDX_W-1:0] o_col,
  output logic                          o_ld,
  output logic                          o_sub_en,
  output logic                          o_win_done
);

  import box_pkg::*;

  logic [COL_IDX_W-1:0] col_cnt;
  logic [ROW_IDX_W-1:0] row_cnt;
  logic [COL_IDX_W-1:0] cur_col;
  logic [ROW_IDX_W-1:0] cur_row;
  logic                 row_end;
  logic                 frame_end;

  // sof marks the pixel it comes with as row 0, column 0
  assign cur_col   = i_sof ? '0 : col_cnt;
  assign cur_row   = i_sof ? '0 : row_cnt;
  assign row_end   = (cur_col == COL_IDX_W'(IMG_COLS - 1));
  assign frame_end = (cur_row == ROW_IDX_W'(IMG_ROWS - 1));

  // ------------------------------
  // position counters
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end else if (i_pix_valid) begin
      if (row_end) begin
        col_cnt <= '0;
        if (frame_end) begin
          row_cnt <= '0;
        end else begin
          row_cnt <= cur_row + 1'b1;
        end
      end else begin
        col_cnt <= cur_col + 1'b1;
        row_cnt <= cur_row;
      end
    end else if (i_sof) begin
      col_cnt <= '0;
      row_cnt <= '0;
    end
  end

  // ------------------------------
  // strobes for the accepted pixel
  // ------------------------------
  assign o_accept   = i_pix_valid;
  assign o_col      = cur_col;
  assign o_ld       = i_pix_valid && (cur_col == '0);
  assign o_sub_en   = i_pix_valid && (cur_col >= WIN);
  assign o_win_done = i_pix_valid && (cur_row >= WIN - 1) && (cur_col >= WIN - 1);

  // rows arrive without holes, gaps only between rows
  a_row_unbroken : assert property (@(posedge clk) disable iff (!rst_n)
    (i_pix_valid && !row_end) |=> i_pix_valid);

endmodule

// ==== src/adder_stage.sv ====
`timescale 1ns/100ps

module adder_stage #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] i_a,
  input  logic [WIDTH-1:0] i_b,
  output logic [WIDTH:0]   o_sum
);

  // one tree node, carry kept in the extra bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_sum <= '0;
    end else begin
      o_sum <= i_a + i_b;
    end
  end

endmodule

// ==== src/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_accept,
  input  logic [box_pkg::COL_IDX_W-1:0] i_col,
  input  box_pkg::pix_t                 i_pix,
  output box_pkg::pix_t                 o_col_pix [box_pkg::WIN],
  output logic                          o_col_valid
);

  import box_pkg::*;

  // row 0 is the oldest row held
  pix_t                          row_mem [WIN-1][IMG_COLS];
  logic [$clog2(IMG_COLS)-1:0]   rd_addr;

  assign rd_addr = i_col[$clog2(IMG_COLS)-1:0];

  // ------------------------------
  // read column, then shift it up
  // ------------------------------
  always_ff @(posedge clk) begin
    if (i_accept) begin
      for (int r = 0; r < WIN - 1; r++) begin
        o_col_pix[r] <= row_mem[r][rd_addr];
      end
      o_col_pix[WIN-1] <= i_pix;

      // every row moves up one, new pixel goes to the bottom row
      for (int r = 0; r < WIN - 2; r++) begin
        row_mem[r][rd_addr] <= row_mem[r+1][rd_addr];
      end
      row_mem[WIN-2][rd_addr] <= i_pix;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_col_valid <= 1'b0;
    end else begin
      o_col_valid <= i_accept;
    end
  end

endmodule

// ==== src/delay_line.sv ====
`timescale 1ns/100ps

module delay_line #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  T     i_d,
  output T     o_q
);

  T stage_q [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < DEPTH; k++) begin
        stage_q[k] <= '0;
      end
    end else begin
      stage_q[0] <= i_d;
      for (int k = 1; k < DEPTH; k++) begin
        stage_q[k] <= stage_q[k-1];
      end
    end
  end

  // oldest entry
  assign o_q = stage_q[DEPTH-1];

endmodule

// ==== src/box_pkg.sv ====
package box_pkg;

  // frame geometry
  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 12;

  // window
  localparam int WIN      = 9;
  localparam int WIN_AREA = WIN * WIN;

  // data widths
  localparam int PIX_W = 8;
  localparam int COL_W = 12;
  // 81 * 255 = 20655 still fits
  localparam int SUM_W = 15;

  localparam int COL_IDX_W = 5;
  localparam int ROW_IDX_W = 5;

  // accepted pixel to o_bin_valid
  localparam int PIPE_LAT = 8;

  typedef logic [PIX_W-1:0] pix_t;
  typedef logic [COL_W-1:0] col_sum_t;
  typedef logic [SUM_W-1:0] win_sum_t;

endpackage
